/* verilog/spi_pkg.sv */
/*
  spi frame types shared by the reader and the byte interface
*/
package spi_pkg;

  // one byte on the wire, also the command byte
  typedef logic [7:0] byte_t;

  // frame length in bytes, command byte included (1..15)
  typedef logic [3:0] len_t;

  // tick counter inside one frame, 16 ticks per byte plus framing
  typedef logic [7:0] step_t;

  // reader control states
  typedef enum logic [1:0] {
    idle   = 2'd0,  // waiting for sync or direct request
    frame  = 2'd1,  // running an spi transfer
    direct = 2'd2   // host owns the sensor pins
  } reader_state_e;

endpackage

/* verilog/accel_pkg.sv */
/*
  accelerometer data types, sample words and buffer entries
*/
package accel_pkg;

  // sensor stream sends each axis as 3 bytes, msb first
  localparam int unsigned BYTES_PER_AXIS = 3;

  // kept part of one axis reading, upper two bytes
  typedef logic [15:0] sample_t;

  typedef enum logic [1:0] {
    axis_x = 2'd0,
    axis_y = 2'd1,
    axis_z = 2'd2
  } axis_e;

  // one buffer word, 19 bits
  // sensor id on top, then axis, then the sample
  typedef struct packed {
    logic    sensor;  // 0 or 1, which miso line
    axis_e   axis;
    sample_t sample;
  } entry_t;

endpackage

/* verilog/spi_byte_if.sv */
/*
  byte pair handoff from the spi reader to the sample packer
*/
interface spi_byte_if;

  logic           valid;  // single cycle strobe, no back-pressure
  spi_pkg::byte_t data0;  // byte from sensor 0
  spi_pkg::byte_t data1;  // byte from sensor 1
  logic           first;  // first data byte after the command byte

  modport reader (
    output valid,
    output data0,
    output data1,
    output first
  );

  modport packer (
    input valid,
    input data0,
    input data1,
    input first
  );

endinterface

/* verilog/accel_spi_reader.sv */
/*
  spi mode 0 master for two sensors on a shared bus
  runs one command frame per sync, shifts in both miso lines, grants direct access
*/
module accel_spi_reader (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           clk_en,       // one bit step per tick
  input  logic           sync,
  input  spi_pkg::byte_t cmd,
  input  spi_pkg::len_t  len,          // bytes in frame, command included
  input  logic           direct,       // host asks for the pins
  input  logic           direct_mosi,
  input  logic           direct_sclk,
  input  logic           direct_csn,
  input  logic           miso0,
  input  logic           miso1,
  output logic           sensor_mosi,
  output logic           sensor_sclk,
  output logic           sensor_csn,
  output logic           direct_en,    // grant, selects the pin mux
  output logic           busy,
  spi_byte_if.reader     bytes
);

  spi_pkg::reader_state_e state;
  spi_pkg::step_t         step_q;
  spi_pkg::step_t         step_nxt;
  spi_pkg::step_t         end_step;    // len * 16, last bit edge sits just past it
  spi_pkg::len_t          len_q;
  spi_pkg::len_t          byte_q;      // completed bytes in this frame
  spi_pkg::byte_t         mosi_sr;     // outgoing command, msb on the wire
  spi_pkg::byte_t         rx0_sr;
  spi_pkg::byte_t         rx1_sr;
  spi_pkg::byte_t         data0_q;
  spi_pkg::byte_t         data1_q;
  logic [7:0]             bit_sr;      // one-hot bit position, bit 7 = last bit of byte
  logic                   csn_q;
  logic                   sclk_q;
  logic                   valid_q;
  logic                   first_q;
  logic                   accept;
  logic                   on_tick;
  logic                   sample_step;
  logic                   fall_step;
  logic                   shift_step;

  assign accept   = (state == spi_pkg::idle) && !direct && sync && (len >= 4'd2);
  assign on_tick  = clk_en && (state == spi_pkg::frame);
  assign step_nxt = step_q + 8'd1;
  assign end_step = {len_q, 4'h0};

  // odd steps raise sclk and sample, even steps drop it and move mosi
  assign sample_step = step_nxt[0] && (step_nxt >= 8'd3) && (step_nxt <= end_step + 8'd1);
  assign fall_step   = !step_nxt[0] && (step_nxt >= 8'd4) && (step_nxt <= end_step + 8'd2);
  assign shift_step  = !step_nxt[0] && (step_nxt >= 8'd4) && (step_nxt <= end_step);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state   <= spi_pkg::idle;
      step_q  <= '0;
      byte_q  <= '0;
      csn_q   <= 1'b1;
      sclk_q  <= 1'b0;
      valid_q <= 1'b0;
      first_q <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b0;  // strobe only
      case (state)
        spi_pkg::idle:
        begin
          if (direct)
            state <= spi_pkg::direct;  // sampled only here, between frames
          else if (accept)
          begin
            state  <= spi_pkg::frame;
            step_q <= '0;
            byte_q <= '0;
          end
        end
        spi_pkg::frame:
        begin
          if (clk_en)
          begin
            step_q <= step_nxt;
            if (step_nxt == 8'd1)
              csn_q <= 1'b0;
            if (sample_step)
            begin
              sclk_q <= 1'b1;
              if (bit_sr[7])  // eighth bit of this byte
              begin
                byte_q  <= byte_q + 4'd1;
                valid_q <= (byte_q != 4'd0);  // skip the command byte
                first_q <= (byte_q == 4'd1);
              end
            end
            if (fall_step)
              sclk_q <= 1'b0;
            if (step_nxt == end_step + 8'd3)
              csn_q <= 1'b1;  // one tick after the last byte
            if (step_nxt == end_step + 8'd4)
              state <= spi_pkg::idle;  // busy drops here
          end
        end
        spi_pkg::direct:
          if (!direct)
            state <= spi_pkg::idle;
        default:
          state <= spi_pkg::idle;
      endcase
    end
  end

  // shift datapath
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      len_q   <= len;
      mosi_sr <= cmd;    // cmd[7] is on mosi before the first rising edge
      bit_sr  <= 8'h01;
    end
    else if (on_tick)
    begin
      if (shift_step)
        mosi_sr <= {mosi_sr[6:0], 1'b0};  // zeros after the command
      if (sample_step)
      begin
        rx0_sr <= {rx0_sr[6:0], miso0};
        rx1_sr <= {rx1_sr[6:0], miso1};
        bit_sr <= {bit_sr[6:0], bit_sr[7]};
        if (bit_sr[7])
        begin
          data0_q <= {rx0_sr[6:0], miso0};
          data1_q <= {rx1_sr[6:0], miso1};
        end
      end
    end
  end

  assign busy      = (state == spi_pkg::frame);
  assign direct_en = (state == spi_pkg::direct);

  // pin mux, host pins pass straight through while granted
  assign sensor_csn  = direct_en ? direct_csn  : csn_q;
  assign sensor_sclk = direct_en ? direct_sclk : sclk_q;
  assign sensor_mosi = direct_en ? direct_mosi : mosi_sr[7];

  assign bytes.valid = valid_q;
  assign bytes.data0 = data0_q;
  assign bytes.data1 = data1_q;
  assign bytes.first = first_q;

  a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
    bytes.valid |=> !bytes.valid);

  // chip select must hold through every bit of the frame
  a_csn_frame: assert property (@(posedge clk) disable iff (!rst_n)
    (state == spi_pkg::frame && step_q >= 8'd1 && step_q <= end_step + 8'd2) |-> !sensor_csn);

endmodule

/* verilog/sample_packer.sv */
/*
  sample packer, keeps the two high bytes of each axis group
  and writes one entry per sensor per axis
*/
module sample_packer (
  input  logic              clk,
  input  logic              rst_n,
  spi_byte_if.packer        bytes,
  output logic              wr,        // buffer write strobe
  output accel_pkg::entry_t wr_entry
);

  localparam int CNT_W = $clog2(accel_pkg::BYTES_PER_AXIS);

  logic [CNT_W-1:0]  cnt_q;       // byte position in current axis group
  logic [CNT_W-1:0]  pos;         // position of the byte arriving now
  accel_pkg::axis_e  axis_q;
  accel_pkg::axis_e  axis_cur;
  accel_pkg::axis_e  axis_nxt;
  spi_pkg::byte_t    hi0_q;       // high byte, sensor 0
  spi_pkg::byte_t    hi1_q;       // high byte, sensor 1
  accel_pkg::entry_t pend_entry;  // sensor 1 entry, goes out one cycle late
  logic              pend_q;

  // first byte of a frame restarts the group at x
  assign pos      = bytes.first ? '0 : cnt_q;
  assign axis_cur = bytes.first ? accel_pkg::axis_x : axis_q;

  always_comb
  begin
    case (axis_cur)
      accel_pkg::axis_x: axis_nxt = accel_pkg::axis_y;
      accel_pkg::axis_y: axis_nxt = accel_pkg::axis_z;
      default:           axis_nxt = accel_pkg::axis_x;  // z wraps back
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cnt_q  <= '0;
      axis_q <= accel_pkg::axis_x;
      wr     <= 1'b0;
      pend_q <= 1'b0;
    end
    else
    begin
      wr     <= pend_q;  // second write of the pair
      pend_q <= 1'b0;
      if (bytes.valid)
      begin
        if (pos == CNT_W'(accel_pkg::BYTES_PER_AXIS - 1))
        begin
          cnt_q  <= '0;  // low byte dropped, next axis
          axis_q <= axis_nxt;
        end
        else
        begin
          cnt_q  <= pos + 1'b1;
          axis_q <= axis_cur;
        end
        if (pos == CNT_W'(1))
        begin
          wr     <= 1'b1;  // sensor 0 entry next cycle
          pend_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (bytes.valid && pos == '0)
    begin
      hi0_q <= bytes.data0;
      hi1_q <= bytes.data1;
    end
    if (bytes.valid && pos == CNT_W'(1))
    begin
      wr_entry   <= accel_pkg::entry_t'{sensor: 1'b0, axis: axis_cur,
                                        sample: {hi0_q, bytes.data0}};
      pend_entry <= accel_pkg::entry_t'{sensor: 1'b1, axis: axis_cur,
                                        sample: {hi1_q, bytes.data1}};
    end
    else if (pend_q)
      wr_entry <= pend_entry;
  end

  // reader spacing must leave room for both writes of a pair
  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    bytes.valid |-> !(pend_q || wr));

endmodule

/* verilog/sample_ring_buffer.sv */
/*
  ring buffer for sample entries
  wrapping write pointer, registered read port, oldest entries overwritten
*/
module sample_ring_buffer #(
  parameter int DEPTH_LOG2 = 6
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr,
  input  accel_pkg::entry_t     wr_entry,
  input  logic [DEPTH_LOG2-1:0] rd_addr,
  output accel_pkg::entry_t     rd_data,   // valid one cycle after rd_addr
  output logic [DEPTH_LOG2-1:0] wr_ptr     // next slot to write
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  accel_pkg::entry_t mem [DEPTH];

  // pointer wraps by natural overflow
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      wr_ptr <= '0;
    else if (wr)
      wr_ptr <= wr_ptr + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (wr)
      mem[wr_ptr] <= wr_entry;  // same edge as the pointer step
  end

  always_ff @(posedge clk)
  begin
    rd_data <= mem[rd_addr];  // read before write on a collision
  end

endmodule

/* verilog/accel_capture_top.sv */
/*
  dual accelerometer capture, spi reader into packer into ring buffer
*/
module accel_capture_top #(
  parameter int DEPTH_LOG2 = 6
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clk_en,
  input  logic                  sync,
  input  spi_pkg::byte_t        cmd,
  input  spi_pkg::len_t         len,
  input  logic                  direct,
  input  logic                  direct_mosi,
  input  logic                  direct_sclk,
  input  logic                  direct_csn,
  input  logic                  miso0,
  input  logic                  miso1,
  input  logic [DEPTH_LOG2-1:0] rd_addr,
  output logic                  sensor_mosi,
  output logic                  sensor_sclk,
  output logic                  sensor_csn,
  output logic                  direct_en,
  output logic                  busy,
  output accel_pkg::entry_t     rd_data,
  output logic [DEPTH_LOG2-1:0] wr_ptr
);

  logic              wr;        // packer to buffer
  accel_pkg::entry_t wr_entry;

  spi_byte_if i_bytes ();

  accel_spi_reader i_reader (
    .clk         (clk),
    .rst_n       (rst_n),
    .clk_en      (clk_en),
    .sync        (sync),
    .cmd         (cmd),
    .len         (len),
    .direct      (direct),
    .direct_mosi (direct_mosi),
    .direct_sclk (direct_sclk),
    .direct_csn  (direct_csn),
    .miso0       (miso0),
    .miso1       (miso1),
    .sensor_mosi (sensor_mosi),
    .sensor_sclk (sensor_sclk),
    .sensor_csn  (sensor_csn),
    .direct_en   (direct_en),
    .busy        (busy),
    .bytes       (i_bytes.reader)
  );

  sample_packer i_packer (
    .clk      (clk),
    .rst_n    (rst_n),
    .bytes    (i_bytes.packer),
    .wr       (wr),
    .wr_entry (wr_entry)
  );

  sample_ring_buffer #(
    .DEPTH_LOG2 (DEPTH_LOG2)
  ) i_buffer (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .wr_entry (wr_entry),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .wr_ptr   (wr_ptr)
  );

endmodule

/* test/adxl_pair_model.sv */
/*
  two spi mode 0 sensors on one bus with separate miso lines
  records the command byte, serves data bytes from random tables
*/
module adxl_pair_model (
  input  logic csn,
  input  logic sclk,
  input  logic mosi,
  output logic miso0,
  output logic miso1
);

  spi_pkg::byte_t tab0 [1024];  // sensor 0 data, index frame * 16 + data byte
  spi_pkg::byte_t tab1 [1024];  // sensor 1 data, same layout
  spi_pkg::byte_t cmd_seen;     // first byte of the latest frame
  spi_pkg::byte_t rx_sr;
  spi_pkg::byte_t tx0;
  spi_pkg::byte_t tx1;
  int             frame_cnt;    // csn falling edges seen so far
  int             cur_frame;
  int             byte_cnt;     // whole bytes in the current csn-low period
  int             bit_cnt;
  integer         seed;

  initial
  begin
    int i;
    seed      = 32'h9df0_454a;
    frame_cnt = 0;
    cur_frame = 0;
    byte_cnt  = 0;
    bit_cnt   = 0;
    cmd_seen  = '0;
    miso0     = 1'b0;
    miso1     = 1'b0;
    for (i = 0; i < 1024; i++)
    begin
      tab0[i] = spi_pkg::byte_t'($random(seed));
      tab1[i] = spi_pkg::byte_t'($random(seed));
    end
  end

  // next byte pair to shift out, the command slot carries filler
  task automatic load_bytes();
    int idx;
    if (byte_cnt == 0)
    begin
      tx0 = 8'ha5;
      tx1 = 8'h5a;
    end
    else
    begin
      idx = (cur_frame * 16 + byte_cnt - 1) % 1024;
      tx0 = tab0[idx];
      tx1 = tab1[idx];
    end
  endtask

  always @(negedge csn)
  begin
    cur_frame = frame_cnt;
    frame_cnt = frame_cnt + 1;
    byte_cnt  = 0;
    bit_cnt   = 0;
    load_bytes();
    miso0 = tx0[7];  // first bit out before the first rising edge
    miso1 = tx1[7];
  end

  always @(posedge sclk)
  begin
    if (csn == 1'b0)
    begin
      rx_sr   = {rx_sr[6:0], mosi};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 8)
      begin
        if (byte_cnt == 0)
          cmd_seen = rx_sr;
        byte_cnt = byte_cnt + 1;
        bit_cnt  = 0;
      end
    end
  end

  // mode 0, miso moves on the falling edge
  always @(negedge sclk)
  begin
    if (csn == 1'b0)
    begin
      if (bit_cnt == 0)
        load_bytes();
      else
      begin
        tx0 = {tx0[6:0], 1'b0};
        tx1 = {tx1[6:0], 1'b0};
      end
      miso0 = tx0[7];
      miso1 = tx1[7];
    end
  end

endmodule

/* test/tb_accel_capture.sv */
/*
  testbench for the dual accelerometer capture
  runs frames against the sensor model, checks the buffer against a reference
*/
module tb_accel_capture;

  localparam int DEPTH_LOG2  = 6;
  localparam int DEPTH       = 1 << DEPTH_LOG2;
  localparam int RAND_FRAMES = 30;
  localparam int RUN_FRAMES  = RAND_FRAMES + 8;
  localparam int FRAME_CLKS  = (15 * 16 + 4) * 4 + 64;  // len 15 at one tick per 4 clocks
  localparam int WATCHDOG    = (RUN_FRAMES * FRAME_CLKS + 4 * DEPTH + 500) * 10;

  typedef logic [DEPTH_LOG2-1:0] ptr_t;

  logic              clk;
  logic              rst_n;
  logic              clk_en;
  logic              sync;
  spi_pkg::byte_t    cmd;
  spi_pkg::len_t     len;
  logic              direct;
  logic              direct_mosi;
  logic              direct_sclk;
  logic              direct_csn;
  logic              miso0;
  logic              miso1;
  ptr_t              rd_addr;
  logic              sensor_mosi;
  logic              sensor_sclk;
  logic              sensor_csn;
  logic              direct_en;
  logic              busy;
  accel_pkg::entry_t rd_data;
  ptr_t              wr_ptr;

  accel_pkg::entry_t exp_q [$];  // every entry the buffer should hold, oldest first
  int                frames;     // csn-low periods the model should have seen
  integer            seed;

  accel_capture_top #(
    .DEPTH_LOG2 (DEPTH_LOG2)
  ) i_accel_capture_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .clk_en      (clk_en),
    .sync        (sync),
    .cmd         (cmd),
    .len         (len),
    .direct      (direct),
    .direct_mosi (direct_mosi),
    .direct_sclk (direct_sclk),
    .direct_csn  (direct_csn),
    .miso0       (miso0),
    .miso1       (miso1),
    .rd_addr     (rd_addr),
    .sensor_mosi (sensor_mosi),
    .sensor_sclk (sensor_sclk),
    .sensor_csn  (sensor_csn),
    .direct_en   (direct_en),
    .busy        (busy),
    .rd_data     (rd_data),
    .wr_ptr      (wr_ptr)
  );

  adxl_pair_model i_adxl_pair_model (
    .csn   (sensor_csn),
    .sclk  (sensor_sclk),
    .mosi  (sensor_mosi),
    .miso0 (miso0),
    .miso1 (miso1)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // clk_en on every fourth clock
  initial
  begin
    int n;
    n      = 0;
    clk_en = 1'b0;
    forever
    begin
      @(posedge clk);
      n = (n + 1) % 4;
      clk_en <= (n == 0);
    end
  end

  initial
  begin
    #(WATCHDOG);
    $display("watchdog expired before all frames finished");
    fail_run();
  end

  task automatic fail_run();
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_entry(string name, accel_pkg::entry_t got, accel_pkg::entry_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_byte(string name, spi_pkg::byte_t got, spi_pkg::byte_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_ptr(string name, ptr_t got, ptr_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_pin(string name, logic got, logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  // expected entries of model frame n, an axis is written once its two high bytes are in
  function automatic void expect_frame(int n, spi_pkg::len_t len_v);
    accel_pkg::entry_t e;
    int                ndata;
    int                g;
    int                hi;
    int                bpa;
    bpa   = int'(accel_pkg::BYTES_PER_AXIS);
    ndata = int'(len_v) - 1;  // command byte carries no data
    for (g = 0; g * bpa + 1 < ndata; g++)
    begin
      hi       = (n * 16 + g * bpa) % 1024;
      e.axis   = accel_pkg::axis_e'(g % 3);  // x, y, z, then x again
      e.sensor = 1'b0;
      e.sample = {i_adxl_pair_model.tab0[hi], i_adxl_pair_model.tab0[hi + 1]};
      exp_q.push_back(e);
      e.sensor = 1'b1;
      e.sample = {i_adxl_pair_model.tab1[hi], i_adxl_pair_model.tab1[hi + 1]};
      exp_q.push_back(e);
    end
  endfunction

  task automatic read_entry(int k);
    @(posedge clk);
    rd_addr <= ptr_t'(k);
    @(posedge clk);  // read port registers here
    @(negedge clk);
    check_entry($sformatf("rd_data[%0d]", k % DEPTH), rd_data, exp_q[k]);
  endtask

  // one sync frame, poke sends a second sync while busy
  task automatic run_frame(spi_pkg::byte_t c, spi_pkg::len_t l, logic poke);
    int first_new;
    int k;
    first_new = exp_q.size();
    expect_frame(frames, l);
    frames++;
    @(posedge clk);
    cmd  <= c;
    len  <= l;
    sync <= 1'b1;
    @(posedge clk);
    sync <= 1'b0;
    @(negedge clk);
    if (busy !== 1'b1)
    begin
      $display("busy did not rise the cycle after sync");
      fail_run();
    end
    if (poke)
    begin
      @(posedge clk);
      sync <= 1'b1;
      len  <= 4'd15;
      @(posedge clk);
      sync <= 1'b0;
    end
    while (busy)
      @(negedge clk);
    repeat (4) @(negedge clk);
    check_byte("model cmd_seen", i_adxl_pair_model.cmd_seen, c);
    check_byte("model byte_cnt", spi_pkg::byte_t'(i_adxl_pair_model.byte_cnt),
               spi_pkg::byte_t'(l));
    check_byte("model frame_cnt", spi_pkg::byte_t'(i_adxl_pair_model.frame_cnt),
               spi_pkg::byte_t'(frames));
    check_ptr("wr_ptr", wr_ptr, ptr_t'(exp_q.size()));
    for (k = first_new; k < exp_q.size(); k++)
      read_entry(k);
  endtask

  task automatic direct_access();
    int i;
    @(posedge clk);
    direct <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_pin("direct_en", direct_en, 1'b1);
    for (i = 0; i < 8; i++)
    begin
      @(posedge clk);
      {direct_csn, direct_sclk, direct_mosi} <= 3'(7 - i);  // csn drops halfway
      @(negedge clk);
      check_pin("sensor_csn", sensor_csn, direct_csn);
      check_pin("sensor_sclk", sensor_sclk, direct_sclk);
      check_pin("sensor_mosi", sensor_mosi, direct_mosi);
    end
    @(posedge clk);
    direct_csn <= 1'b1;
    frames++;  // the model saw that csn pulse
    @(posedge clk);
    sync <= 1'b1;
    @(posedge clk);
    sync <= 1'b0;
    for (i = 0; i < 32; i++)
    begin
      @(negedge clk);
      check_pin("busy", busy, 1'b0);
    end
    check_ptr("wr_ptr", wr_ptr, ptr_t'(exp_q.size()));
    check_byte("model frame_cnt", spi_pkg::byte_t'(i_adxl_pair_model.frame_cnt),
               spi_pkg::byte_t'(frames));
    @(posedge clk);
    direct <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_pin("direct_en", direct_en, 1'b0);
  endtask

  initial
  begin
    int i;
    int k;
    seed        = 32'h9df0_454a;
    frames      = 0;
    rst_n       = 1'b0;
    sync        = 1'b0;
    cmd         = '0;
    len         = '0;
    direct      = 1'b0;
    direct_mosi = 1'b0;
    direct_sclk = 1'b0;
    direct_csn  = 1'b1;
    rd_addr     = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_ptr("wr_ptr", wr_ptr, '0);
    check_pin("busy", busy, 1'b0);
    run_frame(8'h08, 4'd10, 1'b0);  // three full axes
    run_frame(8'h11, 4'd8, 1'b0);   // lone trailing byte
    run_frame(8'h0e, 4'd2, 1'b0);
    run_frame(8'h09, 4'd15, 1'b0);
    run_frame(8'h08, 4'd10, 1'b1);  // extra sync while busy
    direct_access();
    run_frame(8'h08, 4'd10, 1'b0);
    for (i = 0; i < RAND_FRAMES; i++)
      run_frame(spi_pkg::byte_t'($random(seed)),
                spi_pkg::len_t'(4 + {$random(seed)} % 12), 1'b0);
    if (exp_q.size() <= DEPTH)
    begin
      $display("random frames did not wrap the write pointer");
      fail_run();
    end
    check_ptr("wr_ptr", wr_ptr, ptr_t'(exp_q.size()));
    // newest full depth of entries
    for (k = exp_q.size() - DEPTH; k < exp_q.size(); k++)
      read_entry(k);
    $display("All tests passed");
    $finish;
  end

endmodule

/* files.f */
verilog/spi_pkg.sv
verilog/accel_pkg.sv
verilog/spi_byte_if.sv
verilog/accel_spi_reader.sv
verilog/sample_packer.sv
verilog/sample_ring_buffer.sv
verilog/accel_capture_top.sv
test/adxl_pair_model.sv
test/tb_accel_capture.sv

/* run.sh */
#!/bin/sh
# builds the capture testbench with verilator and runs it
# a $fatal in the simulation gives a failing exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -j 0 \
  -f files.f --top-module tb_accel_capture -o sim_tb_accel_capture &&
./obj_dir/sim_tb_accel_capture ||
{ echo "simulation build or run failed"; exit 1; }
